// File: common/mmioPkg.sv
`default_nettype none

package mmioPkg;

	// CPU side bus
	localparam int ADDR_WIDTH = 13; // Word address from CPU
	localparam int DATA_WIDTH = 32; // Bus word

	// Address map fields
	localparam int REGION_BIT = 12; // Set selects coprocessor window
	localparam int SEL_LSB = 7; // Coprocessor select field start
	localparam int SEL_WIDTH = 5; // Bits 11..7
	localparam int SPEC_LSB = 2; // Register select field start
	localparam int SPEC_WIDTH = 5; // Bits 6..2

	// Coprocessor indices in the window
	localparam int COPROC_PLAYER1 = 0; // Player 1 physics
	localparam int COPROC_PLAYER2 = 1; // Player 2 physics
	localparam int COPROC_TIMER = 2; // Frame timer

	// Timer readable registers
	localparam int TIMER_REG_COUNT = 0; // Frame count

endpackage

`default_nettype wire

// File: common/physicsPkg.sv
`default_nettype none

package physicsPkg;

	// Coordinates and velocities
	localparam int COORD_WIDTH = 16; // Per axis, signed
	typedef logic signed [COORD_WIDTH-1:0] coordT;

	// Write registers of a physics core
	localparam int REG_GRAVITY = 0; // Added to vy in force phase
	localparam int REG_WIND = 1; // Added to vx in force phase
	localparam int REG_START = 2; // {x,y} load, clears motion
	localparam int REG_FLOOR = 3; // Lowest y allowed
	localparam int REG_CONTROL = 4; // Bit 0 freeze, bits 15..8 push

	// Read registers of a physics core
	localparam int RD_POSITION = 0; // {x,y}
	localparam int RD_VELOCITY = 1; // {vx,vy}
	localparam int RD_STEPS = 2; // Completed steps

	// Phases of one physics step
	typedef enum logic [1:0] {
		phaseIdle,
		phaseForce,
		phaseMove,
		phaseClamp
	} stepPhaseT;

endpackage

`default_nettype wire

// File: common/regBusIf.sv
`default_nettype none

interface regBusIf import mmioPkg::*; ();

	logic coprocWrite; // One cycle write strobe into window
	logic [SEL_WIDTH-1:0] select; // Which coprocessor
	logic [SPEC_WIDTH-1:0] spec; // Which register
	logic [DATA_WIDTH-1:0] writeData; // Straight from CPU

	// Decoder side, write data comes from the top level
	modport master (
		output coprocWrite, select, spec
	);

	modport target (
		input coprocWrite, select, spec, writeData
	);

endinterface

`default_nettype wire

// File: source/dataMemory.sv
`default_nettype none

module dataMemory import mmioPkg::*; #(
	parameter int MEM_ADDR_BITS = 12
) (
	input wire logic clock,
	input wire logic writeEn,
	input wire logic [MEM_ADDR_BITS-1:0] address,
	input wire logic [DATA_WIDTH-1:0] writeData,
	output logic [DATA_WIDTH-1:0] readData
);

	localparam int DEPTH = 2 ** MEM_ADDR_BITS; // Words

	logic [DATA_WIDTH-1:0] memArray [DEPTH];

	always_ff @(posedge clock) begin
		if (writeEn) begin
			memArray[address] <= writeData;
		end
		readData <= memArray[address]; // Old word on a write cycle
	end

endmodule

`default_nettype wire

// File: physics/frameTimer.sv
`default_nettype none

module frameTimer import mmioPkg::*; #(
	parameter int FRAME_CYCLES = 1000
) (
	input wire logic clock,
	input wire logic reset,
	output logic framePulse,
	output logic [DATA_WIDTH-1:0] frameCount
);

	localparam int COUNT_BITS = $clog2(FRAME_CYCLES); // Holds 0 .. FRAME_CYCLES-1

	logic [COUNT_BITS-1:0] cycleCount;
	logic atWrap;

	assign atWrap = (cycleCount == COUNT_BITS'(FRAME_CYCLES - 1));

	always_ff @(posedge clock) begin
		if (reset) begin
			cycleCount <= '0;
			framePulse <= 1'b0;
			frameCount <= '0;
		end else begin
			cycleCount <= atWrap ? '0 : cycleCount + 1'b1;
			framePulse <= atWrap; // Single cycle per frame
			if (atWrap) begin
				frameCount <= frameCount + 1'b1; // Same edge as pulse
			end
		end
	end

endmodule

`default_nettype wire

// File: physics/stepSequencer.sv
`default_nettype none

module stepSequencer import physicsPkg::*; (
	input wire logic clock,
	input wire logic reset,
	input wire logic framePulse,
	output stepPhaseT phase
);

	stepPhaseT nextPhase;

	// Fixed walk, one cycle per active phase
	always_comb begin
		case (phase)
			phaseIdle: nextPhase = framePulse ? phaseForce : phaseIdle;
			phaseForce: nextPhase = phaseMove;
			phaseMove: nextPhase = phaseClamp;
			phaseClamp: nextPhase = phaseIdle; // Step done
			default: nextPhase = phaseIdle;
		endcase
	end

	// Pulses outside idle are dropped
	// a frame is far longer than one step
	always_ff @(posedge clock) begin
		if (reset) begin
			phase <= phaseIdle;
		end else begin
			phase <= nextPhase;
		end
	end

endmodule

`default_nettype wire

// File: physics/physicsCore.sv
`default_nettype none

module physicsCore import mmioPkg::*, physicsPkg::*; #(
	parameter int PLAYER_INDEX = 0
) (
	input wire logic clock,
	input wire logic reset,
	regBusIf.target bus,
	input wire stepPhaseT phase,
	output logic [DATA_WIDTH-1:0] coreReadData
);

	coordT gravity, wind, floorLevel; // Per frame settings
	logic [COORD_WIDTH-1:0] control; // Freeze and push byte
	coordT posX, posY;
	coordT velX, velY;
	logic active; // Core joined the current step
	logic [DATA_WIDTH-1:0] stepCount;

	logic regWrite; // Write aimed at this core
	logic startLoad;
	logic frozen;
	coordT push; // Signed control byte

	assign regWrite = bus.coprocWrite && (bus.select == SEL_WIDTH'(PLAYER_INDEX));
	assign startLoad = regWrite && (bus.spec == SPEC_WIDTH'(REG_START));
	assign frozen = control[0];
	assign push = coordT'(signed'(control[15:8])); // Sign extend

	// Settings registers
	always_ff @(posedge clock) begin
		if (reset) begin
			gravity <= '0;
			wind <= '0;
			floorLevel <= '0;
			control <= COORD_WIDTH'(1); // Frozen out of reset
		end else if (regWrite) begin
			case (bus.spec)
				SPEC_WIDTH'(REG_GRAVITY): gravity <= bus.writeData[COORD_WIDTH-1:0];
				SPEC_WIDTH'(REG_WIND): wind <= bus.writeData[COORD_WIDTH-1:0];
				SPEC_WIDTH'(REG_FLOOR): floorLevel <= bus.writeData[COORD_WIDTH-1:0];
				SPEC_WIDTH'(REG_CONTROL): control <= bus.writeData[COORD_WIDTH-1:0];
				default: ; // Start handled with motion state
			endcase
		end
	end

	// Motion state, start load wins over any phase
	always_ff @(posedge clock) begin
		if (reset) begin
			posX <= '0;
			posY <= '0;
			velX <= '0;
			velY <= '0;
			active <= 1'b0;
			stepCount <= '0;
		end else if (startLoad) begin
			posX <= bus.writeData[2*COORD_WIDTH-1:COORD_WIDTH]; // x upper half
			posY <= bus.writeData[COORD_WIDTH-1:0];
			velX <= '0;
			velY <= '0;
			active <= 1'b0; // Abandon a step in flight
			stepCount <= '0;
		end else begin
			case (phase)
				phaseForce: begin
					active <= ~frozen; // Freeze sampled here only
					if (!frozen) begin
						velX <= velX + wind + push;
						velY <= velY + gravity;
					end
				end
				phaseMove: begin
					if (active) begin
						posX <= posX + velX;
						posY <= posY + velY;
					end
				end
				phaseClamp: begin
					if (active) begin
						if (posY >= floorLevel) begin // Signed compare
							posY <= floorLevel;
							velY <= '0; // Landed
						end
						stepCount <= stepCount + 1'b1;
					end
					active <= 1'b0;
				end
				default: ; // Idle holds state
			endcase
		end
	end

	// Readback, decoder picks by select
	always_comb begin
		case (bus.spec)
			SPEC_WIDTH'(RD_POSITION): coreReadData = {posX, posY};
			SPEC_WIDTH'(RD_VELOCITY): coreReadData = {velX, velY};
			SPEC_WIDTH'(RD_STEPS): coreReadData = stepCount;
			default: coreReadData = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: source/mmioDecoder.sv
`default_nettype none

module mmioDecoder import mmioPkg::*; #(
	parameter int MEM_ADDR_BITS = 12
) (
	input wire logic clock,
	input wire logic reset,
	input wire logic [ADDR_WIDTH-1:0] address,
	input wire logic writeEn,
	output logic memWriteEn,
	output logic [MEM_ADDR_BITS-1:0] memAddress,
	input wire logic [DATA_WIDTH-1:0] memReadData,
	input wire logic [DATA_WIDTH-1:0] player1ReadData,
	input wire logic [DATA_WIDTH-1:0] player2ReadData,
	input wire logic [DATA_WIDTH-1:0] frameCount,
	regBusIf.master bus,
	output logic [DATA_WIDTH-1:0] readData
);

	logic inWindow; // Current access hits coprocessors
	logic [SEL_WIDTH-1:0] coprocSelect;
	logic [SPEC_WIDTH-1:0] coprocSpec;
	logic [DATA_WIDTH-1:0] coprocNext; // Readback before register
	logic windowQ; // Region of last access
	logic [DATA_WIDTH-1:0] coprocQ; // Aligned with memory read

	assign inWindow = address[REGION_BIT];
	assign coprocSelect = address[SEL_LSB +: SEL_WIDTH];
	assign coprocSpec = address[SPEC_LSB +: SPEC_WIDTH];

	// Memory side
	assign memWriteEn = writeEn & ~inWindow;
	assign memAddress = address[MEM_ADDR_BITS-1:0];

	// Coprocessor side
	assign bus.coprocWrite = writeEn & inWindow;
	assign bus.select = coprocSelect;
	assign bus.spec = coprocSpec;

	always_comb begin
		case (coprocSelect)
			SEL_WIDTH'(COPROC_PLAYER1): coprocNext = player1ReadData;
			SEL_WIDTH'(COPROC_PLAYER2): coprocNext = player2ReadData;
			SEL_WIDTH'(COPROC_TIMER): begin
				coprocNext = (coprocSpec == SPEC_WIDTH'(TIMER_REG_COUNT)) ? frameCount : '0;
			end
			default: coprocNext = '0; // Unused slots read zero
		endcase
	end

	// Reset points the output at the cleared coprocessor word
	// so readData is zero before any memory read happens
	always_ff @(posedge clock) begin
		if (reset) begin
			windowQ <= 1'b1;
			coprocQ <= '0;
		end else begin
			windowQ <= inWindow;
			coprocQ <= coprocNext;
		end
	end

	assign readData = windowQ ? coprocQ : memReadData; // One cycle latency

endmodule

`default_nettype wire

// File: source/mmioTop.sv
`default_nettype none

module mmioTop import mmioPkg::*, physicsPkg::*; #(
	parameter int FRAME_CYCLES = 1000,
	parameter int MEM_ADDR_BITS = 12
) (
	input wire logic clock,
	input wire logic reset,
	input wire logic [ADDR_WIDTH-1:0] address,
	input wire logic [DATA_WIDTH-1:0] writeData,
	input wire logic writeEn,
	output logic [DATA_WIDTH-1:0] readData
);

	logic memWriteEn;
	logic [MEM_ADDR_BITS-1:0] memAddress;
	logic [DATA_WIDTH-1:0] memReadData;
	logic [DATA_WIDTH-1:0] player1ReadData, player2ReadData;
	logic [DATA_WIDTH-1:0] frameCount;
	logic framePulse;
	stepPhaseT phase; // Shared by both cores

	regBusIf coprocBus ();

	assign coprocBus.writeData = writeData; // Same word for every coprocessor

	mmioDecoder #(.MEM_ADDR_BITS(MEM_ADDR_BITS)) decoder (
		.clock(clock), .reset(reset),
		.address(address), .writeEn(writeEn),
		.memWriteEn(memWriteEn), .memAddress(memAddress), .memReadData(memReadData),
		.player1ReadData(player1ReadData), .player2ReadData(player2ReadData),
		.frameCount(frameCount),
		.bus(coprocBus.master),
		.readData(readData)
	);

	dataMemory #(.MEM_ADDR_BITS(MEM_ADDR_BITS)) dataMem (
		.clock(clock), .writeEn(memWriteEn), .address(memAddress),
		.writeData(writeData), .readData(memReadData)
	);

	frameTimer #(.FRAME_CYCLES(FRAME_CYCLES)) timer (
		.clock(clock), .reset(reset),
		.framePulse(framePulse), .frameCount(frameCount)
	);

	stepSequencer sequencer (
		.clock(clock), .reset(reset),
		.framePulse(framePulse), .phase(phase)
	);

	physicsCore #(.PLAYER_INDEX(COPROC_PLAYER1)) player1 (
		.clock(clock), .reset(reset),
		.bus(coprocBus.target), .phase(phase), .coreReadData(player1ReadData)
	);

	physicsCore #(.PLAYER_INDEX(COPROC_PLAYER2)) player2 (
		.clock(clock), .reset(reset),
		.bus(coprocBus.target), .phase(phase), .coreReadData(player2ReadData)
	);

endmodule

`default_nettype wire

// File: testbench/mmioTb.sv
`default_nettype none

module mmioTb import mmioPkg::*, physicsPkg::*;;

	localparam int FRAME_CYCLES = 64; // Short frames for simulation
	localparam int POLL_MARGIN = 32; // Extra cycles on frame polls
	localparam int MEM_WRITES = 32;

	logic clock;
	logic reset;
	logic [ADDR_WIDTH-1:0] address;
	logic [DATA_WIDTH-1:0] writeData;
	logic writeEn;
	logic [DATA_WIDTH-1:0] readData;

	integer seed; // Random stream
	logic [31:0] randWord;
	logic [5:0] memAddr [MEM_WRITES]; // Small range forces repeats
	logic [31:0] memModel [64]; // Latest write per word
	logic [31:0] readWord;
	coordT gravity1, wind1, floor1;
	logic [7:0] push1;
	logic [31:0] start1;
	logic [63:0] p1Expected, p2Expected; // {x,y,vx,vy}
	logic [31:0] p1Steps, p2Steps;

	mmioTop #(.FRAME_CYCLES(FRAME_CYCLES)) i_dut (
		.clock(clock), .reset(reset),
		.address(address), .writeData(writeData), .writeEn(writeEn),
		.readData(readData)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock; // Period 20
	end

	// Window address from coprocessor and register index
	function automatic logic [ADDR_WIDTH-1:0] coprocAddress(input int sel, input int spec);
		coprocAddress = {1'b1, sel[4:0], spec[4:0], 2'b00};
	endfunction

	// One physics step on a model state
	function automatic logic [63:0] stepPlayer(input logic [63:0] state, input coordT gravity,
		input coordT wind, input coordT push, input coordT floorLevel);
		coordT x, y, vx, vy;
		{x, y, vx, vy} = state;
		vx = vx + wind + push; // Force
		vy = vy + gravity;
		x = x + vx; // Move
		y = y + vy;
		if (y >= floorLevel) begin // Clamp, signed
			y = floorLevel;
			vy = '0;
		end
		stepPlayer = {x, y, vx, vy};
	endfunction

	task automatic abortRun(input string what);
		$display("ERROR at %0t: %s", $time, what);
		$display("Result: FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("FAIL time=%0t signal=%s got=0x%08h expected=0x%08h",
				$time, name, got, expected);
			$display("Result: FAILED");
			$fatal(1, "mismatch");
		end
	endtask

	task automatic cpuWrite(input logic [ADDR_WIDTH-1:0] addr, input logic [31:0] data);
		address = addr;
		writeData = data;
		writeEn = 1'b1; // Lands on next edge
		@(posedge clock);
		#2;
		writeEn = 1'b0;
	endtask

	task automatic cpuRead(input logic [ADDR_WIDTH-1:0] addr, output logic [31:0] data);
		address = addr;
		writeEn = 1'b0;
		@(posedge clock); // One cycle latency
		#2;
		data = readData;
	endtask

	// A step lasts three cycles after the pulse
	task automatic settleStep();
		repeat (4) @(posedge clock);
		#2;
	endtask

	// Poll frame count until it has advanced by frames
	task automatic waitFrames(input int frames);
		logic [31:0] startCount;
		logic [31:0] lastCount;
		logic [31:0] nowCount;
		int cycles;
		cpuRead(coprocAddress(COPROC_TIMER, TIMER_REG_COUNT), startCount);
		lastCount = startCount;
		nowCount = startCount;
		cycles = 0;
		while (nowCount - startCount < 32'(frames)) begin
			if (cycles > frames * FRAME_CYCLES + POLL_MARGIN) begin
				abortRun("frame count did not advance within the timeout");
			end else begin
				cpuRead(coprocAddress(COPROC_TIMER, TIMER_REG_COUNT), nowCount);
				cycles++; // One read per cycle
				if (nowCount < lastCount) begin
					abortRun("frame count went backwards");
				end else begin
					lastCount = nowCount;
				end
			end
		end
	endtask

	task automatic checkPlayer(input int sel, input logic [63:0] expected,
		input logic [31:0] steps);
		logic [31:0] got;
		cpuRead(coprocAddress(sel, RD_POSITION), got);
		checkValue($sformatf("player%0d position", sel + 1), got, expected[63:32]);
		cpuRead(coprocAddress(sel, RD_VELOCITY), got);
		checkValue($sformatf("player%0d velocity", sel + 1), got, expected[31:0]);
		cpuRead(coprocAddress(sel, RD_STEPS), got);
		checkValue($sformatf("player%0d steps", sel + 1), got, steps);
	endtask

	// Load, run some frames, freeze, compare with model
	task automatic runPlayer(input int sel, input coordT gravity, input coordT wind,
		input logic [7:0] pushByte, input coordT floorLevel, input logic [31:0] start,
		input int frames, output logic [63:0] expected, output logic [31:0] steps);
		coordT push;
		push = {{8{pushByte[7]}}, pushByte}; // Signed push byte
		cpuWrite(coprocAddress(sel, REG_START), start); // Still frozen
		cpuWrite(coprocAddress(sel, REG_GRAVITY), {16'h0, gravity});
		cpuWrite(coprocAddress(sel, REG_WIND), {16'h0, wind});
		cpuWrite(coprocAddress(sel, REG_FLOOR), {16'h0, floorLevel});
		cpuWrite(coprocAddress(sel, REG_CONTROL), {16'h0, pushByte, 8'h00}); // Unfreeze
		waitFrames(frames);
		cpuWrite(coprocAddress(sel, REG_CONTROL), {16'h0, pushByte, 8'h01}); // Freeze
		settleStep();
		cpuRead(coprocAddress(sel, RD_STEPS), steps);
		checkValue("step count in range",
			32'((steps >= 32'(frames)) && (steps <= 32'(frames + 1))), 32'd1);
		expected = {start, 32'h0}; // Motion cleared by start load
		for (int i = 0; i < int'(steps); i++) begin
			expected = stepPlayer(expected, gravity, wind, push, floorLevel);
		end
		checkPlayer(sel, expected, steps);
	endtask

	initial begin
		seed = 32'he11e79fe;
		reset = 1'b1;
		address = '0;
		writeData = '0;
		writeEn = 1'b0;
		repeat (2) @(posedge clock);
		#2;
		reset = 1'b0;

		// Reset state
		checkPlayer(COPROC_PLAYER1, 64'h0, 32'h0);
		checkPlayer(COPROC_PLAYER2, 64'h0, 32'h0);
		cpuRead(coprocAddress(COPROC_TIMER, TIMER_REG_COUNT), readWord);
		checkValue("frameCount", readWord, 32'h0);

		// Data memory against array model
		for (int i = 0; i < MEM_WRITES; i++) begin
			randWord = $random(seed);
			memAddr[i] = randWord[5:0];
			randWord = $random(seed);
			memModel[memAddr[i]] = randWord; // Latest wins
			cpuWrite({7'd0, memAddr[i]}, randWord);
		end
		for (int i = 0; i < MEM_WRITES; i++) begin
			cpuRead({7'd0, memAddr[i]}, readWord);
			checkValue($sformatf("mem[%0d]", memAddr[i]), readWord, memModel[memAddr[i]]);
		end

		// Frame timer keeps counting
		waitFrames(3);

		// Player 1 with random small forces
		randWord = $random(seed);
		gravity1 = coordT'({14'd0, randWord[1:0]} + 16'd1); // 1 .. 4
		wind1 = {{13{randWord[4]}}, randWord[4:2]}; // -4 .. 3
		push1 = {{5{randWord[7]}}, randWord[7:5]};
		floor1 = 16'd40;
		start1 = {8'd0, randWord[15:8], 16'hffd8}; // y starts at -40
		runPlayer(COPROC_PLAYER1, gravity1, wind1, push1, floor1, start1, 5,
			p1Expected, p1Steps);

		// Player 2 lands hard, player 1 untouched
		runPlayer(COPROC_PLAYER2, 16'd100, 16'd0, 8'd0, 16'd55, {16'd10, 16'd50}, 3,
			p2Expected, p2Steps);
		cpuRead(coprocAddress(COPROC_PLAYER2, RD_POSITION), readWord);
		checkValue("player2 y", {16'h0, readWord[15:0]}, 32'd55); // On the floor
		cpuRead(coprocAddress(COPROC_PLAYER2, RD_VELOCITY), readWord);
		checkValue("player2 vy", {16'h0, readWord[15:0]}, 32'd0);
		checkPlayer(COPROC_PLAYER1, p1Expected, p1Steps);

		// Unused slots read zero and ignore writes
		cpuRead(coprocAddress(5, 0), readWord);
		checkValue("unused coprocessor", readWord, 32'h0);
		cpuRead(coprocAddress(COPROC_PLAYER1, 7), readWord);
		checkValue("unused player register", readWord, 32'h0);
		cpuRead(coprocAddress(COPROC_TIMER, 3), readWord);
		checkValue("unused timer register", readWord, 32'h0);
		cpuWrite(coprocAddress(5, REG_START), $random(seed)); // Start load if select ignored
		cpuWrite(coprocAddress(COPROC_PLAYER1, 31), $random(seed));
		cpuWrite(coprocAddress(COPROC_PLAYER2, 9), $random(seed));
		cpuRead(coprocAddress(5, REG_START), readWord);
		checkValue("unused coprocessor after write", readWord, 32'h0);
		cpuRead(coprocAddress(COPROC_PLAYER1, 31), readWord);
		checkValue("unused register after write", readWord, 32'h0);
		checkPlayer(COPROC_PLAYER1, p1Expected, p1Steps);
		checkPlayer(COPROC_PLAYER2, p2Expected, p2Steps);

		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
common/mmioPkg.sv
common/physicsPkg.sv
common/regBusIf.sv
source/dataMemory.sv
physics/frameTimer.sv
physics/stepSequencer.sv
physics/physicsCore.sv
source/mmioDecoder.sv
source/mmioTop.sv
testbench/mmioTb.sv

// File: Makefile
TOP := mmioTb

.PHONY: all lint clean

all:
	verilator --binary --timing -f src.f --top-module $(TOP) -o simv
	out=$$(./obj_dir/simv 2>&1); echo "$$out"; echo "$$out" | grep -q "Result: PASSED"

lint:
	verilator --lint-only --timing -f src.f --top-module mmioTop

clean:
	rm -rf obj_dir
